/* Makefile */
# Verilator build for the risc8 core testbench

VERILATOR  ?= verilator
TOP        ?= risc8_tb
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= --lint-only
BUILD_JOBS ?= 4

.PHONY: all lint sim build clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(BUILD_JOBS) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)

# The binary exits non-zero when the testbench stops on $fatal
sim: build
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* verification/risc8_chk.sv */
`timescale 1ns/1ps

module risc8_chk (
        input logic                   clk,
        input logic                   rst_n,
        input logic                   dec_valid,
        input risc8_pkg::ctrl_t       dec_ctrl,
        input logic                   res_valid,
        input logic                   res_ready,
        input risc8_pkg::result_pkt_t res_pkt
);

        int fail_count = 0; // Failed assertions so far

        // Reset is synchronous, so it shows one edge later
        reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !res_valid)
                else begin
                        $error("res_valid is high after a reset edge");
                        fail_count++;
                end

        stall_holds_output: assert property (@(posedge clk) disable iff (!rst_n)
                res_valid && !res_ready |=> res_valid && $stable(res_pkt))
                else begin
                        $error("Output packet changed or dropped while stalled");
                        fail_count++;
                end

        // A free output register takes every writing word on the next edge
        ready_when_free: assert property (@(posedge clk) disable iff (!rst_n)
                (res_ready || !res_valid) && dec_valid && dec_ctrl.rw_en
                |=> res_valid && res_pkt.dst == $past(dec_ctrl.a1))
                else begin
                        $error("A writing word was not taken although the output was free");
                        fail_count++;
                end

endmodule

bind risc8_execute risc8_chk i_risc8_chk (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .dec_ctrl  (dec_ctrl),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_pkt   (res_pkt)
);

/* verification/risc8_tb.sv */
`timescale 1ns/1ps

module risc8_tb;

        localparam int NUM_RANDOM      = 400;
        localparam int NUM_DIRECTED    = 8;
        localparam int WATCHDOG_CYCLES = (NUM_RANDOM + NUM_DIRECTED) * 4 + 100;

        logic                   clk;
        logic                   rst_n;
        logic                   in_valid;
        logic                   in_ready;
        risc8_pkg::instr_pkt_t  in_pkt;
        logic                   res_valid;
        logic                   res_ready;
        risc8_pkg::result_pkt_t res_pkt;

        logic [31:0]            lcg_state;
        logic                   burst_mode; // Holds res_ready high and arms the latency check
        int                     cycle;
        risc8_pkg::word         model_regs [4];
        risc8_pkg::result_pkt_t exp_q [$];
        int                     acc_q [$];
        bit                     timed_q [$];

        // Burst run from all-zero registers, a no-op sits in the middle
        logic [15:0] directed [NUM_DIRECTED] = '{16'h2600, 16'hA000, 16'hB800, 16'h0C5A,
                                                 16'hC500, 16'h9800, 16'h1700, 16'h7400};

        risc8_core i_risc8_core (
                .clk       (clk),
                .rst_n     (rst_n),
                .in_valid  (in_valid),
                .in_ready  (in_ready),
                .in_pkt    (in_pkt),
                .res_valid (res_valid),
                .res_ready (res_ready),
                .res_pkt   (res_pkt)
        );

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        function automatic logic [31:0] lcg_next();
                lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
                return lcg_state;
        endfunction

        function automatic int assertion_failures();
                return i_risc8_core.i_risc8_execute.i_risc8_chk.fail_count;
        endfunction

        task automatic fail_run(input string msg);
                $display("%s", msg);
                $display("STATUS: FAIL");
                $fatal(1, "Simulation stopped after a failed check");
        endtask

        task automatic compare_result(input risc8_pkg::result_pkt_t got,
                                      input risc8_pkg::result_pkt_t exp);
                if (got !== exp) begin
                        fail_run($sformatf("** Error [%0t] got R%0d=%02h, expected R%0d=%02h",
                                           $time, got.dst, got.data, exp.dst, exp.data));
                end
        endtask

        task automatic compare_latency(input int got, input int exp);
                if (got != exp) begin
                        fail_run($sformatf("** Error [%0t] latency: got %0d cycles, expected %0d",
                                           $time, got, exp));
                end
        endtask

        task automatic idle_check();
                if (exp_q.size() != 0) begin
                        fail_run($sformatf("%0d expected results never came out of the core",
                                           exp_q.size()));
                end
                if (res_valid !== 1'b0) begin
                        fail_run("The core still shows a valid result after all were taken");
                end
        endtask

        // Applies one accepted instruction to the model registers
        task automatic apply_model(input risc8_pkg::instr_pkt_t pkt, input bit timed);
                logic [1:0]             d;
                logic [1:0]             s;
                risc8_pkg::word         x;
                risc8_pkg::word         y;
                risc8_pkg::word         v;
                bit                     wr;
                risc8_pkg::result_pkt_t e;
                d  = pkt.instr[3:2];
                s  = pkt.instr[1:0];
                x  = model_regs[d];
                y  = model_regs[s];
                v  = x;
                wr = 1'b1;
                case (pkt.instr[7:4])
                        4'd0:  v = pkt.imm;
                        4'd1:  v = y;
                        4'd2:  v = x + y;
                        4'd3:  v = x - y;
                        4'd4:  v = x & y;
                        4'd5:  v = x | y;
                        4'd6:  v = x ^ y;
                        4'd7:  v = x << y[2:0];
                        4'd8:  v = x >> y[2:0];
                        4'd9: begin
                                repeat (y[2:0]) v = {v[7], v[7:1]}; // Bit 7 fills from the top
                        end
                        4'd10: v = x + 8'd1;
                        4'd11: v = x - 8'd1;
                        default: wr = 1'b0;
                endcase
                if (wr) begin
                        model_regs[d] = v;
                        e.dst  = risc8_pkg::e_reg_addr'(d);
                        e.data = v;
                        exp_q.push_back(e);
                        acc_q.push_back(cycle);
                        timed_q.push_back(timed);
                end
        endtask

        task automatic check_result();
                if (exp_q.size() == 0) begin
                        fail_run("A result came out with no writing instruction pending");
                end
                compare_result(res_pkt, exp_q[0]);
                if (timed_q[0]) begin
                        compare_latency(cycle - acc_q[0], 2);
                end
                void'(exp_q.pop_front());
                void'(acc_q.pop_front());
                void'(timed_q.pop_front());
        endtask

        always @(posedge clk) begin
                cycle = cycle + 1;
                if (assertion_failures() != 0) begin
                        fail_run("An assertion on the execute stage failed");
                end
                if (rst_n) begin
                        if (res_valid && res_ready) begin
                                check_result();
                        end
                        if (in_valid && in_ready) begin
                                apply_model(in_pkt, burst_mode);
                        end
                end
        end

        task automatic next_cycle();
                logic [31:0] r;
                @(negedge clk);
                r = lcg_next();
                res_ready = burst_mode ? 1'b1 : (r[17:16] != 2'b00);
        endtask

        // Returns on the falling edge after the core took the instruction
        task automatic send_instr(input risc8_pkg::instr_pkt_t pkt, input bit gaps);
                logic [31:0] r;
                r = lcg_next();
                while (gaps && r[17:16] == 2'b00) begin
                        in_valid = 1'b0;
                        next_cycle();
                        r = lcg_next();
                end
                in_valid = 1'b1;
                in_pkt   = pkt;
                @(posedge clk);
                while (!in_ready) begin
                        if (burst_mode) begin
                                fail_run("Input stalled in a burst with res_ready high");
                        end
                        next_cycle();
                        @(posedge clk);
                end
                next_cycle();
        endtask

        initial begin
                repeat (WATCHDOG_CYCLES) @(posedge clk);
                fail_run($sformatf("Timeout: the run did not end within %0d cycles",
                                   WATCHDOG_CYCLES));
        end

        initial begin
                risc8_pkg::instr_pkt_t pkt;
                logic [31:0]           r;
                lcg_state  = 32'hc503c232;
                rst_n      = 1'b0;
                in_valid   = 1'b0;
                in_pkt     = '0;
                res_ready  = 1'b1;
                burst_mode = 1'b1;
                cycle      = 0;
                for (int i = 0; i < 4; i++) begin
                        model_regs[i] = '0;
                end
                repeat (5) @(posedge clk);
                @(negedge clk);
                rst_n = 1'b1;

                for (int i = 0; i < NUM_DIRECTED; i++) begin
                        send_instr(risc8_pkg::instr_pkt_t'(directed[i]), 1'b0);
                end
                in_valid = 1'b0;
                repeat (4) next_cycle();
                idle_check();

                burst_mode = 1'b0; // Random stalls on both sides from here
                for (int i = 0; i < NUM_RANDOM; i++) begin
                        r         = lcg_next();
                        pkt.instr = r[23:16];
                        pkt.imm   = r[31:24];
                        send_instr(pkt, 1'b1);
                end
                in_valid   = 1'b0;
                burst_mode = 1'b1;
                repeat (20) next_cycle();
                idle_check();

                if (assertion_failures() != 0) begin
                        fail_run("An assertion on the execute stage failed");
                end else begin
                        $display("STATUS: PASS");
                        $finish;
                end
        end

endmodule

/* verilog/risc8_alu.sv */
`timescale 1ns/1ps

module risc8_alu (
        input  risc8_pkg::e_alu_op op,
        input  risc8_pkg::word     a,
        input  risc8_pkg::word     b,
        output risc8_pkg::word     y
);

        logic [2:0] shamt;

        // Only the low three bits matter for an 8-bit shift
        assign shamt = b[2:0];

        always_comb begin
                case (op)
                        risc8_pkg::ALU_ADD: begin
                                y = a + b; // Wraps modulo 256
                        end
                        risc8_pkg::ALU_SUB: begin
                                y = a - b;
                        end
                        risc8_pkg::ALU_AND: begin
                                y = a & b;
                        end
                        risc8_pkg::ALU_OR: begin
                                y = a | b;
                        end
                        risc8_pkg::ALU_XOR: begin
                                y = a ^ b;
                        end
                        risc8_pkg::ALU_SL: begin
                                y = a << shamt;
                        end
                        risc8_pkg::ALU_SR: begin
                                y = a >> shamt;
                        end
                        risc8_pkg::ALU_RA: begin
                                // Sign bit is copied into the vacated positions
                                y = risc8_pkg::word'($signed(a) >>> shamt);
                        end
                        default: begin
                                y = a;
                        end
                endcase
        end

endmodule

/* verilog/risc8_core.sv */
`timescale 1ns/1ps

module risc8_core (
        input  logic                   clk,
        input  logic                   rst_n,
        input  logic                   in_valid,
        output logic                   in_ready,
        input  risc8_pkg::instr_pkt_t  in_pkt,
        output logic                   res_valid,
        input  logic                   res_ready,
        output risc8_pkg::result_pkt_t res_pkt
);

        // Link between the decode and execute stages
        logic             dec_valid;
        logic             dec_ready;
        risc8_pkg::ctrl_t dec_ctrl;

        risc8_decode i_risc8_decode (
                .clk       (clk),
                .rst_n     (rst_n),
                .in_valid  (in_valid),
                .in_ready  (in_ready),
                .in_pkt    (in_pkt),
                .dec_valid (dec_valid),
                .dec_ready (dec_ready),
                .dec_ctrl  (dec_ctrl)
        );

        risc8_execute i_risc8_execute (
                .clk       (clk),
                .rst_n     (rst_n),
                .dec_valid (dec_valid),
                .dec_ready (dec_ready),
                .dec_ctrl  (dec_ctrl),
                .res_valid (res_valid),
                .res_ready (res_ready),
                .res_pkt   (res_pkt)
        );

endmodule

/* verilog/risc8_decode.sv */
`timescale 1ns/1ps

module risc8_decode (
        input  logic                   clk,
        input  logic                   rst_n,
        input  logic                   in_valid,
        output logic                   in_ready,
        input  risc8_pkg::instr_pkt_t  in_pkt,
        output logic                   dec_valid,
        input  logic                   dec_ready,
        output risc8_pkg::ctrl_t       dec_ctrl
);

        risc8_pkg::e_opcode op;
        risc8_pkg::ctrl_t   ctrl_next;

        assign op = risc8_pkg::e_opcode'(in_pkt.instr[7:4]);

        always_comb begin
                ctrl_next.alu_op = risc8_pkg::ALU_ADD;
                ctrl_next.selb   = risc8_pkg::SB_NONE;
                ctrl_next.selr   = risc8_pkg::SR_NONE;
                ctrl_next.rw_en  = 1'b1;
                ctrl_next.a1     = risc8_pkg::e_reg_addr'(in_pkt.instr[3:2]);
                ctrl_next.a2     = risc8_pkg::e_reg_addr'(in_pkt.instr[1:0]);
                ctrl_next.imm    = in_pkt.imm;
                case (op)
                        risc8_pkg::OP_CPY:  ctrl_next.selr = risc8_pkg::SR_IMM;
                        risc8_pkg::OP_MOVE: ctrl_next.selr = risc8_pkg::SR_REG;
                        risc8_pkg::OP_ADD: begin
                                ctrl_next.selb = risc8_pkg::SB_REG;
                                ctrl_next.selr = risc8_pkg::SR_ALU;
                        end
                        risc8_pkg::OP_SUB: begin
                                ctrl_next.alu_op = risc8_pkg::ALU_SUB;
                                ctrl_next.selb   = risc8_pkg::SB_REG;
                                ctrl_next.selr   = risc8_pkg::SR_ALU;
                        end
                        risc8_pkg::OP_AND: begin
                                ctrl_next.alu_op = risc8_pkg::ALU_AND;
                                ctrl_next.selb   = risc8_pkg::SB_REG;
                                ctrl_next.selr   = risc8_pkg::SR_ALU;
                        end
                        risc8_pkg::OP_OR: begin
                                ctrl_next.alu_op = risc8_pkg::ALU_OR;
                                ctrl_next.selb   = risc8_pkg::SB_REG;
                                ctrl_next.selr   = risc8_pkg::SR_ALU;
                        end
                        risc8_pkg::OP_XOR: begin
                                ctrl_next.alu_op = risc8_pkg::ALU_XOR;
                                ctrl_next.selb   = risc8_pkg::SB_REG;
                                ctrl_next.selr   = risc8_pkg::SR_ALU;
                        end
                        risc8_pkg::OP_SLL: begin
                                ctrl_next.alu_op = risc8_pkg::ALU_SL;
                                ctrl_next.selb   = risc8_pkg::SB_REG;
                                ctrl_next.selr   = risc8_pkg::SR_ALU;
                        end
                        risc8_pkg::OP_SRL: begin
                                ctrl_next.alu_op = risc8_pkg::ALU_SR;
                                ctrl_next.selb   = risc8_pkg::SB_REG;
                                ctrl_next.selr   = risc8_pkg::SR_ALU;
                        end
                        risc8_pkg::OP_SRA: begin
                                ctrl_next.alu_op = risc8_pkg::ALU_RA;
                                ctrl_next.selb   = risc8_pkg::SB_REG;
                                ctrl_next.selr   = risc8_pkg::SR_ALU;
                        end
                        risc8_pkg::OP_INC: begin
                                ctrl_next.selb = risc8_pkg::SB_1; // ADD with constant one
                                ctrl_next.selr = risc8_pkg::SR_ALU;
                        end
                        risc8_pkg::OP_DEC: begin
                                ctrl_next.alu_op = risc8_pkg::ALU_SUB;
                                ctrl_next.selb   = risc8_pkg::SB_1;
                                ctrl_next.selr   = risc8_pkg::SR_ALU;
                        end
                        default: ctrl_next.rw_en = 1'b0; // Opcodes 12 to 15 do nothing
                endcase
        end

        // Stage accepts when empty or when its word leaves this cycle
        assign in_ready = !dec_valid || dec_ready;

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        dec_valid <= 1'b0;
                end else if (in_ready) begin
                        dec_valid <= in_valid;
                end
        end

        always_ff @(posedge clk) begin
                if (in_valid && in_ready) begin
                        dec_ctrl <= ctrl_next;
                end
        end

endmodule

/* verilog/risc8_execute.sv */
`timescale 1ns/1ps

module risc8_execute (
        input  logic                   clk,
        input  logic                   rst_n,
        input  logic                   dec_valid,
        output logic                   dec_ready,
        input  risc8_pkg::ctrl_t       dec_ctrl,
        output logic                   res_valid,
        input  logic                   res_ready,
        output risc8_pkg::result_pkt_t res_pkt
);

        logic           consume;
        logic           wr_en;
        risc8_pkg::word rd1;
        risc8_pkg::word rd2;
        risc8_pkg::word opb;
        risc8_pkg::word alu_y;
        risc8_pkg::word wr_data;

        // Output register can take a new packet when empty or draining
        assign dec_ready = !res_valid || res_ready;
        assign consume   = dec_valid && dec_ready;
        assign wr_en     = consume && dec_ctrl.rw_en;

        risc8_regfile i_risc8_regfile (
                .clk   (clk),
                .rst_n (rst_n),
                .ra1   (dec_ctrl.a1),
                .ra2   (dec_ctrl.a2),
                .rd1   (rd1),
                .rd2   (rd2),
                .we    (wr_en),
                .wa    (dec_ctrl.a1),
                .wd    (wr_data)
        );

        always_comb begin
                case (dec_ctrl.selb)
                        risc8_pkg::SB_REG: opb = rd2;
                        risc8_pkg::SB_1:   opb = 8'd1;
                        default:           opb = '0;
                endcase
        end

        risc8_alu i_risc8_alu (
                .op (dec_ctrl.alu_op),
                .a  (rd1),
                .b  (opb),
                .y  (alu_y)
        );

        always_comb begin
                case (dec_ctrl.selr)
                        risc8_pkg::SR_IMM: wr_data = dec_ctrl.imm;
                        risc8_pkg::SR_REG: wr_data = rd2; // MOVE copies the second register
                        risc8_pkg::SR_ALU: wr_data = alu_y;
                        default:           wr_data = '0;
                endcase
        end

        // No-ops pass through here without raising res_valid
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        res_valid <= 1'b0;
                end else if (dec_ready) begin
                        res_valid <= dec_valid && dec_ctrl.rw_en;
                end
        end

        always_ff @(posedge clk) begin
                if (wr_en) begin
                        res_pkt.dst  <= dec_ctrl.a1;
                        res_pkt.data <= wr_data;
                end
        end

endmodule

/* verilog/risc8_pkg.sv */
package risc8_pkg;

        // Data byte and instruction byte share one width
        typedef logic [7:0] word;

        typedef enum logic [1:0] {
                R0 = 2'd0,
                R1 = 2'd1,
                R2 = 2'd2,
                R3 = 2'd3
        } e_reg_addr;

        // Upper nibble of the instruction byte, 12 to 15 decode as no-op
        typedef enum logic [3:0] {
                OP_CPY  = 4'd0,
                OP_MOVE = 4'd1,
                OP_ADD  = 4'd2,
                OP_SUB  = 4'd3,
                OP_AND  = 4'd4,
                OP_OR   = 4'd5,
                OP_XOR  = 4'd6,
                OP_SLL  = 4'd7,
                OP_SRL  = 4'd8,
                OP_SRA  = 4'd9,
                OP_INC  = 4'd10,
                OP_DEC  = 4'd11
        } e_opcode;

        typedef enum logic [2:0] {
                ALU_ADD = 3'd0,
                ALU_SUB = 3'd1,
                ALU_AND = 3'd2,
                ALU_OR  = 3'd3,
                ALU_XOR = 3'd4,
                ALU_SL  = 3'd5,
                ALU_SR  = 3'd6,
                ALU_RA  = 3'd7
        } e_alu_op;

        typedef enum logic [1:0] {
                SB_REG  = 2'd0,
                SB_1    = 2'd1,
                SB_NONE = 2'd2
        } e_selb;

        typedef enum logic [1:0] {
                SR_IMM  = 2'd0,
                SR_REG  = 2'd1,
                SR_ALU  = 2'd2,
                SR_NONE = 2'd3
        } e_selr;

        typedef struct packed {
                word instr;
                word imm;
        } instr_pkt_t;

        typedef struct packed {
                e_alu_op   alu_op;
                e_selb     selb;
                e_selr     selr;
                logic      rw_en;
                e_reg_addr a1; // Destination and first source
                e_reg_addr a2;
                word       imm;
        } ctrl_t;

        typedef struct packed {
                e_reg_addr dst;
                word       data;
        } result_pkt_t;

endpackage

/* verilog/risc8_regfile.sv */
`timescale 1ns/1ps

module risc8_regfile (
        input  logic                 clk,
        input  logic                 rst_n,
        input  risc8_pkg::e_reg_addr ra1,
        input  risc8_pkg::e_reg_addr ra2,
        output risc8_pkg::word       rd1,
        output risc8_pkg::word       rd2,
        input  logic                 we,
        input  risc8_pkg::e_reg_addr wa,
        input  risc8_pkg::word       wd
);

        risc8_pkg::word regs [4];

        // Reads see the value before this edge's write
        assign rd1 = regs[ra1];
        assign rd2 = regs[ra2];

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        for (int i = 0; i < 4; i++) begin
                                regs[i] <= '0;
                        end
                end else if (we) begin
                        regs[wa] <= wd;
                end
        end

endmodule

/* vlog.f */
verilog/risc8_pkg.sv
verilog/risc8_alu.sv
verilog/risc8_regfile.sv
verilog/risc8_decode.sv
verilog/risc8_execute.sv
verilog/risc8_core.sv
verification/risc8_chk.sv
verification/risc8_tb.sv
